// ==== Bender.yml ====
package:
  name: decodeFrontEnd

sources:
  # Packages first, then the blocks bottom up
  - files:
      - source/rvIsaPkg.sv
      - source/frontEndPkg.sv
      - source/fetchUnit.sv
      - source/instQueue.sv
      - source/instDecoder.sv
      - source/decodeFrontEnd.sv

  - target: test
    files:
      - bench/tbDecodeFrontEnd.sv

// ==== bench/tbDecodeFrontEnd.sv ====
`default_nettype none

module tbDecodeFrontEnd;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS     = 64;
    localparam int BASIC_COUNT   = 24;
    localparam int RANDOM_COUNT  = 40;
    localparam int ILLEGAL_COUNT = 16;
    localparam int PRE_COUNT     = 10;
    localparam int POST_COUNT    = 20;
    localparam int TOTAL_COUNT   = BASIC_COUNT + RANDOM_COUNT + ILLEGAL_COUNT
                                   + PRE_COUNT + POST_COUNT;
    localparam int CYCLE_LIMIT   = 8 * TOTAL_COUNT + 100;

    logic                     clk;
    logic                     rst;
    logic                     start;
    logic [31:0]              startPc;
    logic                     fetchEnable;
    logic                     memReq;
    logic [31:0]              memAddr;
    logic [31:0]              memData;
    logic                     consumeEnable;
    logic                     outStrobe;
    frontEndPkg::decodedInstT outInst;

    logic [31:0]              mem [MEM_WORDS];
    frontEndPkg::decodedInstT expInst;
    logic [31:0]              expPc        = '0;
    logic [31:0]              expAddr      = '0;
    logic                     startSeen    = 1'b0;
    int                       cycleCount   = 0;
    int                       strobeCount  = 0;
    int                       illegalCount = 0;
    int                       errorCount   = 0;
    int                       testCount    = 0;
    int                       failedTests  = 0;
    integer                   seed         = 32'h9ec3_7347;

    decodeFrontEnd i_dut (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .startPc      (startPc),
        .fetchEnable  (fetchEnable),
        .memReq       (memReq),
        .memAddr      (memAddr),
        .memData      (memData),
        .consumeEnable(consumeEnable),
        .outStrobe    (outStrobe),
        .outInst      (outInst)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // The word shows up in the cycle after the request
    always @(posedge clk) begin : memModel
        logic [31:0] word;
        logic        hit;
        hit  = memReq;
        word = mem[memAddr[7:2]];
        #2;
        if (hit) begin
            memData = word;
        end
    end

    // ####################
    // Reference decode
    // ####################
    function automatic frontEndPkg::decodedInstT refDecode(input logic [31:0] pc);
        logic [31:0]              w;
        frontEndPkg::decodedInstT d;
        w          = mem[pc[7:2]];
        d          = '0;
        d.pc       = pc;
        d.opcode   = rvIsaPkg::opcodeT'(w[6:0]);
        d.rs1      = w[19:15];
        d.rs2      = w[24:20];
        d.rd       = w[11:7];
        d.funct3   = w[14:12];
        case (w[6:0])
            rvIsaPkg::OP:                       d.instType = rvIsaPkg::R_TYPE;
            rvIsaPkg::LOAD, rvIsaPkg::OP_IMM:   d.instType = rvIsaPkg::I_TYPE;
            rvIsaPkg::JALR, rvIsaPkg::SYSTEM:   d.instType = rvIsaPkg::I_TYPE;
            rvIsaPkg::STORE:                    d.instType = rvIsaPkg::S_TYPE;
            rvIsaPkg::BRANCH:                   d.instType = rvIsaPkg::B_TYPE;
            rvIsaPkg::LUI, rvIsaPkg::AUIPC:     d.instType = rvIsaPkg::U_TYPE;
            rvIsaPkg::JAL:                      d.instType = rvIsaPkg::J_TYPE;
            default:                            d.instType = rvIsaPkg::ILLEGAL_TYPE;
        endcase
        case (d.instType)
            rvIsaPkg::I_TYPE: d.imm = 32'($signed(w[31:20]));
            rvIsaPkg::S_TYPE: d.imm = 32'($signed({w[31:25], w[11:7]}));
            rvIsaPkg::B_TYPE: d.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
            rvIsaPkg::U_TYPE: d.imm = {w[31:12], 12'h000};
            rvIsaPkg::J_TYPE: d.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
            default:          d.imm = '0;
        endcase
        if (d.instType == rvIsaPkg::S_TYPE || d.instType == rvIsaPkg::B_TYPE) begin
            d.rd = '0; // No destination register
        end
        if (d.instType == rvIsaPkg::U_TYPE || d.instType == rvIsaPkg::J_TYPE) begin
            d.funct3 = '0;
        end
        d.regWrite = d.instType inside {rvIsaPkg::R_TYPE, rvIsaPkg::I_TYPE,
                                        rvIsaPkg::U_TYPE, rvIsaPkg::J_TYPE};
        d.memWrite = w[6:0] == rvIsaPkg::STORE;
        d.memRead  = w[6:0] == rvIsaPkg::LOAD;
        d.jump     = w[6:0] == rvIsaPkg::JAL || w[6:0] == rvIsaPkg::JALR;
        d.illegal  = d.instType == rvIsaPkg::ILLEGAL_TYPE;
        return d;
    endfunction

    always_comb expInst = refDecode(outInst.pc);

    // Counts and the expected addresses follow the sampled outputs of each edge
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (!rst && outStrobe) begin
            strobeCount <= strobeCount + 1;
            if (outInst.illegal) begin
                illegalCount <= illegalCount + 1;
            end
        end
        if (start) begin
            expPc   <= startPc;
            expAddr <= startPc;
        end else begin
            if (!rst && outStrobe) begin
                expPc <= expPc + 32'd4;
            end
            if (memReq) begin
                expAddr <= expAddr + 32'd4;
            end
        end
    end

    always @(posedge clk) begin
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d of %0d instructions decoded",
                     cycleCount, strobeCount, TOTAL_COUNT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ####################
    // Assertions
    // ####################
    idleQuiet: assert property (
        @(posedge clk) (cycleCount != 0 && !startSeen) |-> (!memReq && !outStrobe)
    ) else begin
        errorCount++;
        $display("[ERROR] memReq/outStrobe before first start: got %h/%h expected 0/0",
                 $sampled(memReq), $sampled(outStrobe));
    end

    fetchAddress: assert property (
        @(posedge clk) disable iff (rst) memReq |-> memAddr == expAddr
    ) else begin
        errorCount++;
        $display("[ERROR] memAddr: got %h expected %h", $sampled(memAddr),
                 $sampled(expAddr));
    end

    decodeMatch: assert property (
        @(posedge clk) disable iff (rst) outStrobe |-> outInst == expInst
    ) else begin
        errorCount++;
        $display("[ERROR] outInst: got %h expected %h", $sampled(outInst), $sampled(expInst));
    end

    pcSequence: assert property (
        @(posedge clk) disable iff (rst) outStrobe |-> outInst.pc == expPc
    ) else begin
        errorCount++;
        $display("[ERROR] outInst.pc: got %h expected %h", $sampled(outInst.pc),
                 $sampled(expPc));
    end

    // Flags shown as illegal, regWrite, memWrite, memRead, jump
    illegalQuiet: assert property (
        @(posedge clk) disable iff (rst) (outStrobe && expInst.illegal) |->
            {outInst.illegal, outInst.regWrite, outInst.memWrite, outInst.memRead,
             outInst.jump} == 5'h10
    ) else begin
        errorCount++;
        $display("[ERROR] outInst flags: got %h expected 10", $sampled({outInst.illegal,
                 outInst.regWrite, outInst.memWrite, outInst.memRead, outInst.jump}));
    end

    // ####################
    // Stimulus
    // ####################
    task automatic fillMemory();
        rvIsaPkg::opcodeT legalOps [10];
        logic [31:0]      word;
        legalOps = '{rvIsaPkg::LOAD, rvIsaPkg::STORE, rvIsaPkg::BRANCH, rvIsaPkg::OP,
                     rvIsaPkg::OP_IMM, rvIsaPkg::JAL, rvIsaPkg::JALR, rvIsaPkg::LUI,
                     rvIsaPkg::AUIPC, rvIsaPkg::SYSTEM};
        for (int i = 0; i < MEM_WORDS; i++) begin
            word = $random(seed);
            if (i % 8 == 5) begin
                word[1:0] = 2'b00; // Never a 32-bit RV32I opcode
            end else if (i % 4 == 0) begin
                word[6:0] = legalOps[(i / 4) % 10];
            end else begin
                word[6:0] = legalOps[$unsigned($random(seed)) % 10];
            end
            mem[i] = word;
        end
    endtask

    task automatic startPulse(input logic [31:0] pc);
        @(posedge clk);
        #2;
        start     = 1'b1;
        startPc   = pc;
        startSeen = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    task automatic runInstructions(input int count, input bit stall);
        int          target;
        logic [31:0] rnd;
        target = strobeCount + count;
        while (strobeCount < target) begin
            if (stall) begin
                rnd           = $random(seed);
                consumeEnable = rnd[0];
                fetchEnable   = rnd[3:1] != 3'b000; // Fetch mostly on
            end
            @(posedge clk);
            #2;
        end
        consumeEnable = 1'b1;
        fetchEnable   = 1'b1;
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("Test %0d %s: ok", testCount, name);
        end else begin
            failedTests++;
            $display("Test %0d %s: %0d errors", testCount, name, errorCount - errorsBefore);
        end
    endtask

    initial begin : testSequence
        int errorsBefore;
        int illegalBefore;
        rst           = 1'b1;
        start         = 1'b0;
        startPc       = '0;
        fetchEnable   = 1'b0;
        memData       = '0;
        consumeEnable = 1'b0;
        fillMemory();
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        errorsBefore  = errorCount;
        fetchEnable   = 1'b1;
        consumeEnable = 1'b1;
        repeat (6) begin
            @(posedge clk);
            #2;
        end
        finishTest("idle until start", errorsBefore);

        errorsBefore = errorCount;
        startPulse(32'h0000_0000);
        runInstructions(BASIC_COUNT, 1'b0);
        finishTest("decode fields at full rate", errorsBefore);

        errorsBefore = errorCount;
        startPulse(32'h0000_0040);
        runInstructions(RANDOM_COUNT, 1'b1);
        finishTest("pc order under random stalls", errorsBefore);

        errorsBefore  = errorCount;
        startPulse(32'h0000_0080);
        illegalBefore = illegalCount;
        runInstructions(ILLEGAL_COUNT, 1'b0);
        if (illegalCount == illegalBefore) begin
            errorCount++;
            $display("No illegal instruction came out of the run from pc 0x80");
        end
        finishTest("illegal opcodes", errorsBefore);

        // Restart while the queue still holds words of the old sequence
        errorsBefore = errorCount;
        startPulse(32'h0000_0020);
        runInstructions(PRE_COUNT, 1'b1);
        startPulse(32'h0000_00c0);
        runInstructions(POST_COUNT, 1'b1);
        finishTest("restart mid run", errorsBefore);

        $display("Tests: %0d run, %0d failed, %0d errors", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== decodeFrontEnd.f ====
source/rvIsaPkg.sv
source/frontEndPkg.sv
source/fetchUnit.sv
source/instQueue.sv
source/instDecoder.sv
source/decodeFrontEnd.sv
bench/tbDecodeFrontEnd.sv

// ==== source/decodeFrontEnd.sv ====
`default_nettype none

module decodeFrontEnd (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      start,
    input  wire logic [rvIsaPkg::XLEN-1:0] startPc,
    input  wire logic                      fetchEnable,
    output logic                           memReq,
    output logic      [rvIsaPkg::XLEN-1:0] memAddr,
    input  wire logic [rvIsaPkg::XLEN-1:0] memData,
    input  wire logic                      consumeEnable,
    output logic                           outStrobe,
    output frontEndPkg::decodedInstT       outInst
);

    logic                    almostFull;
    logic                    push;
    frontEndPkg::fetchEntryT pushEntry;
    logic                    pop;
    logic                    empty;
    frontEndPkg::fetchEntryT headEntry;

    // ####################
    // Fetch, queue, decode
    // ####################
    fetchUnit uFetch (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .startPc    (startPc),
        .fetchEnable(fetchEnable),
        .almostFull (almostFull),
        .memReq     (memReq),
        .memAddr    (memAddr),
        .memData    (memData),
        .push       (push),
        .pushEntry  (pushEntry)
    );

    instQueue uQueue (
        .clk       (clk),
        .rst       (rst),
        .flush     (start), // A new start empties the queue
        .push      (push),
        .pushEntry (pushEntry),
        .pop       (pop),
        .headEntry (headEntry),
        .empty     (empty),
        .almostFull(almostFull)
    );

    instDecoder uDecoder (
        .clk          (clk),
        .rst          (rst),
        .flush        (start),
        .consumeEnable(consumeEnable),
        .empty        (empty),
        .headEntry    (headEntry),
        .pop          (pop),
        .outStrobe    (outStrobe),
        .outInst      (outInst)
    );

endmodule

`default_nettype wire

// ==== source/fetchUnit.sv ====
`default_nettype none

module fetchUnit (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      start,
    input  wire logic [rvIsaPkg::XLEN-1:0] startPc,
    input  wire logic                      fetchEnable,
    input  wire logic                      almostFull,
    output logic                           memReq,
    output logic      [rvIsaPkg::XLEN-1:0] memAddr,
    input  wire logic [rvIsaPkg::XLEN-1:0] memData,
    output logic                           push,
    output frontEndPkg::fetchEntryT        pushEntry
);

    logic [rvIsaPkg::XLEN-1:0] pc;
    logic                      started;   // Nothing is fetched before the first start
    logic                      pending;   // A read issued last cycle returns now
    logic [rvIsaPkg::XLEN-1:0] pendingPc;

    // No request on the start cycle while pc still holds the old sequence
    assign memReq  = started && fetchEnable && !almostFull && !start;
    assign memAddr = pc;

    // A start drops the word that returns this cycle
    assign push           = pending && !start;
    assign pushEntry.pc   = pendingPc;
    assign pushEntry.inst = memData;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= '0;
            started <= 1'b0;
            pending <= 1'b0;
        end else if (start) begin
            pc      <= startPc;
            started <= 1'b1;
            pending <= 1'b0;
        end else begin
            pending <= memReq;
            if (memReq) begin
                pc <= pc + rvIsaPkg::INST_BYTES;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (memReq) begin
            pendingPc <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== source/frontEndPkg.sv ====
`default_nettype none

package frontEndPkg;

    // ####################
    // Queue sizing
    // ####################
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1); // Count must reach QUEUE_DEPTH

    // One fetched word together with the address it came from
    typedef struct packed {
        logic [rvIsaPkg::XLEN-1:0] pc;
        logic [rvIsaPkg::XLEN-1:0] inst;
    } fetchEntryT;

    // ####################
    // Decoder result
    // ####################
    typedef struct packed {
        logic [rvIsaPkg::XLEN-1:0]      pc;
        rvIsaPkg::opcodeT               opcode;   // Raw bits, may hold an unknown value
        rvIsaPkg::instTypeT             instType;
        logic [rvIsaPkg::REG_IDX_W-1:0] rs1;
        logic [rvIsaPkg::REG_IDX_W-1:0] rs2;
        logic [rvIsaPkg::REG_IDX_W-1:0] rd;
        logic [rvIsaPkg::FUNCT3_W-1:0]  funct3;
        logic [rvIsaPkg::XLEN-1:0]      imm;
        logic                           regWrite;
        logic                           memWrite;
        logic                           memRead;
        logic                           jump;
        logic                           illegal;
    } decodedInstT;

endpackage

`default_nettype wire

// ==== source/instDecoder.sv ====
`default_nettype none

module instDecoder (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    flush,
    input  wire logic                    consumeEnable,
    input  wire logic                    empty,
    input  wire frontEndPkg::fetchEntryT headEntry,
    output logic                         pop,
    output logic                         outStrobe,
    output frontEndPkg::decodedInstT     outInst
);

    logic [rvIsaPkg::XLEN-1:0] inst;
    rvIsaPkg::opcodeT          opc;
    rvIsaPkg::instTypeT        fmt;
    logic [rvIsaPkg::XLEN-1:0] imm;
    frontEndPkg::decodedInstT  decoded;

    assign inst = headEntry.inst;
    assign opc  = rvIsaPkg::opcodeT'(inst[6:0]);

    // Head is read in the same cycle it is popped
    assign pop = !empty && consumeEnable && !flush;

    // ####################
    // Format lookup
    // ####################
    always_comb begin
        case (opc)
            rvIsaPkg::OP: begin
                fmt = rvIsaPkg::R_TYPE;
            end
            rvIsaPkg::LOAD, rvIsaPkg::OP_IMM, rvIsaPkg::JALR, rvIsaPkg::SYSTEM: begin
                fmt = rvIsaPkg::I_TYPE;
            end
            rvIsaPkg::STORE: begin
                fmt = rvIsaPkg::S_TYPE;
            end
            rvIsaPkg::BRANCH: begin
                fmt = rvIsaPkg::B_TYPE;
            end
            rvIsaPkg::LUI, rvIsaPkg::AUIPC: begin
                fmt = rvIsaPkg::U_TYPE;
            end
            rvIsaPkg::JAL: begin
                fmt = rvIsaPkg::J_TYPE;
            end
            default: begin
                fmt = rvIsaPkg::ILLEGAL_TYPE;
            end
        endcase
    end

    // Immediates, sign bit is always inst[31]
    always_comb begin
        case (fmt)
            rvIsaPkg::I_TYPE: imm = {{20{inst[31]}}, inst[31:20]};
            rvIsaPkg::S_TYPE: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            rvIsaPkg::B_TYPE: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            rvIsaPkg::U_TYPE: imm = {inst[31:12], 12'b0};
            rvIsaPkg::J_TYPE: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:          imm = '0; // R and illegal carry no immediate
        endcase
    end

    // ####################
    // Fields and flags
    // ####################
    always_comb begin
        decoded.pc       = headEntry.pc;
        decoded.opcode   = opc;
        decoded.instType = fmt;
        decoded.rs1      = inst[19:15];
        decoded.rs2      = inst[24:20];
        decoded.rd       = (fmt == rvIsaPkg::S_TYPE || fmt == rvIsaPkg::B_TYPE) ? '0 : inst[11:7];
        decoded.funct3   = (fmt == rvIsaPkg::U_TYPE || fmt == rvIsaPkg::J_TYPE) ? '0 : inst[14:12];
        decoded.imm      = imm;
        decoded.regWrite = fmt inside {rvIsaPkg::R_TYPE, rvIsaPkg::I_TYPE,
                                       rvIsaPkg::U_TYPE, rvIsaPkg::J_TYPE};
        decoded.memWrite = opc == rvIsaPkg::STORE;
        decoded.memRead  = opc == rvIsaPkg::LOAD;
        decoded.jump     = opc == rvIsaPkg::JAL || opc == rvIsaPkg::JALR;
        decoded.illegal  = fmt == rvIsaPkg::ILLEGAL_TYPE; // Opcode compares above keep flags low
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outStrobe <= 1'b0;
        end else begin
            outStrobe <= pop; // Low after a flush cycle since pop is held off there
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            outInst <= decoded;
        end
    end

    // The pc comes all the way from fetch through the queue
    pcAligned: assert property (
        @(posedge clk) disable iff (rst) outStrobe |-> outInst.pc[1:0] == 2'b00
    ) else $error("outInst.pc not word aligned: %h", outInst.pc);

endmodule

`default_nettype wire

// ==== source/instQueue.sv ====
`default_nettype none

module instQueue (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    flush,
    input  wire logic                    push,
    input  wire frontEndPkg::fetchEntryT pushEntry,
    input  wire logic                    pop,
    output frontEndPkg::fetchEntryT      headEntry,
    output logic                         empty,
    output logic                         almostFull
);

    frontEndPkg::fetchEntryT             entries [frontEndPkg::QUEUE_DEPTH];
    logic [frontEndPkg::QUEUE_PTR_W-1:0] wrPtr;
    logic [frontEndPkg::QUEUE_PTR_W-1:0] rdPtr;
    logic [frontEndPkg::QUEUE_CNT_W-1:0] count;
    logic                                full;

    function automatic logic [frontEndPkg::QUEUE_PTR_W-1:0] nextPtr(
        input logic [frontEndPkg::QUEUE_PTR_W-1:0] ptr
    );
        if (int'(ptr) == frontEndPkg::QUEUE_DEPTH - 1) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty      = count == '0;
    assign full       = count == frontEndPkg::QUEUE_DEPTH;
    assign almostFull = count >= frontEndPkg::QUEUE_DEPTH - 1; // One slot kept for the read in flight
    assign headEntry  = entries[rdPtr];

    // ####################
    // Pointers and count
    // ####################
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither leave the level alone
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= pushEntry;
        end
    end

    // Overflow would mean the almostFull margin did not hold against fetch
    noPushWhenFull: assert property (
        @(posedge clk) disable iff (rst) !(push && full)
    ) else $error("push into a full queue");

    noPopWhenEmpty: assert property (
        @(posedge clk) disable iff (rst) !(pop && empty)
    ) else $error("pop from an empty queue");

endmodule

`default_nettype wire

// ==== source/rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

    // ####################
    // Field widths
    // ####################
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int FUNCT3_W  = 3;
    localparam int OPCODE_W  = 7;

    localparam logic [XLEN-1:0] INST_BYTES = 4; // Fixed 32-bit encoding, no RVC

    // ####################
    // Major opcodes
    // ####################
    typedef enum logic [OPCODE_W-1:0] {
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        SYSTEM = 7'b1110011
    } opcodeT;

    // Instruction formats, ILLEGAL_TYPE marks anything outside RV32I
    typedef enum logic [2:0] {
        R_TYPE,
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE,
        ILLEGAL_TYPE
    } instTypeT;

endpackage

`default_nettype wire
